// ==== all.f ====
+incdir+hdl
hdl/video_regdec_signals.sv
hdl/video_control_signals.sv
hdl/cpu_bus_axil.sv
hdl/video_regdec.sv
hdl/video_address.sv
hdl/vram_port.sv
hdl/video_regs_top.sv
testbench/tb_video_regs.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_video_regs
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) hdl/ppu_consts.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_video_regs.sv ====
`timescale 1ns/100ps
`include "ppu_consts.svh"

module tb_video_regs
  import video_regdec_signals::*;
  ();

  localparam int WAIT_LIMIT = 40;              // Cycles before a wait gives up.

  logic                        I_clock = 1'b0;
  logic                        I_reset;
  logic[`AXI_ADDR_W-1:0]       awaddr;
  logic                        awvalid;
  wire                         awready;
  logic[`AXI_DATA_W-1:0]       wdata;
  logic[`AXI_DATA_W/8-1:0]     wstrb;
  logic                        wvalid;
  wire                         wready;
  wire[1:0]                    bresp;
  wire                         bvalid;
  logic                        bready;
  logic[`AXI_ADDR_W-1:0]       araddr;
  logic                        arvalid;
  wire                         arready;
  wire[`AXI_DATA_W-1:0]        rdata;
  wire[1:0]                    rresp;
  wire                         rvalid;
  logic                        rready;
  logic                        I_vblank;
  wire[`VID_ADDR_W-1:0]        O_vid_addr;
  wire[2:0]                    O_vid_fine;
  wire[14:0]                   O_scroll_addr;

  int                          check_count = 0;
  int                          error_count = 0;
  logic[31:0]                  lfsr_state = 32'h46ab_db71;

  // Reference model state.
  logic[14:0]                  m_v;
  logic[14:0]                  m_t;
  logic[2:0]                   m_fx;
  logic                        m_w;
  logic[7:0]                   m_ctrl;
  logic[7:0]                   m_mask;
  logic[7:0]                   m_buf;
  bit                          m_buf_known;
  logic[7:0]                   m_mem [int];

  video_regs_top video_regs_top_i (.*);

  always #50 I_clock = ~I_clock;               // 100 ns period.

  // ##########################################################
  // Helpers
  // ##########################################################

  function logic[31:0] lfsr_step(input logic[31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  function logic[7:0] rand_byte();
    logic[7:0] b;
    for (int i = 0; i < 8; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);      // One step for each bit.
      b[i] = lfsr_state[0];
    end
    return b;
  endfunction

  task check_value(input string name, input logic[31:0] got, input logic[31:0] exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task fail_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task model_write(input reg_index_t idx, input logic[7:0] d);
    case (idx)
      R_ppu_ctrl:
      begin
        m_ctrl     = d;
        m_t[11:10] = d[1:0];
      end
      R_ppu_mask: m_mask = d;
      R_ppu_scrl:
      begin
        if (!m_w)
        begin
          m_t[4:0] = d[7:3];
          m_fx     = d[2:0];
        end else
        begin
          m_t[9:5]   = d[7:3];
          m_t[14:12] = d[2:0];
        end
        m_w = ~m_w;
      end
      R_ppu_addr:
      begin
        if (!m_w)
        begin
          m_t[14]   = 1'b0;
          m_t[13:8] = d[5:0];
        end else
        begin
          m_t[7:0] = d;
          m_v      = m_t;
        end
        m_w = ~m_w;
      end
      R_ppu_data:
      begin
        m_mem[int'(m_v[13:0])] = d;
        m_v = m_v + (m_ctrl[2] ? 15'd32 : 15'd1);
      end
      default: ;                               // OAM registers hold nothing.
    endcase
  endtask

  // Returns the expected byte and whether it is known.
  task model_read(input reg_index_t idx, output logic[7:0] exp, output bit known);
    exp = 8'h00;
    known = 1'b1;
    case (idx)
      R_ppu_stat:
      begin
        exp = {I_vblank, 7'd0};
        m_w = 1'b0;
      end
      R_ppu_ctrl: exp = m_ctrl;
      R_ppu_mask: exp = m_mask;
      R_ppu_data:
      begin
        exp = m_buf;
        known = m_buf_known;
        m_buf_known = m_mem.exists(int'(m_v[13:0]));
        if (m_buf_known)
          m_buf = m_mem[int'(m_v[13:0])];
        m_v = m_v + (m_ctrl[2] ? 15'd32 : 15'd1);
      end
      default: ;
    endcase
  endtask

  task check_outputs();
    check_value("O_vid_addr", 32'(O_vid_addr), 32'(m_v[13:0]));
    check_value("O_scroll_addr", 32'(O_scroll_addr), 32'(m_t));
    check_value("O_vid_fine", 32'(O_vid_fine), 32'(m_fx));
  endtask

  // ##########################################################
  // Bus tasks
  // ##########################################################

  task write_addr_data(input reg_index_t idx, input logic[7:0] d, input logic[3:0] strb);
    int n;
    awaddr  = {idx, 2'b00};
    wdata   = {rand_byte(), rand_byte(), rand_byte(), d};
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    #1;
    while (!(awready && wready))
    begin
      if (n == WAIT_LIMIT)
        fail_timeout("write address and data handshake");
      n++;
      @(negedge I_clock);
      #1;
    end
    @(posedge I_clock);
    @(negedge I_clock);
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task wait_bvalid();
    int n;
    n = 0;
    while (!bvalid)
    begin
      if (n == WAIT_LIMIT)
        fail_timeout("write response");
      n++;
      @(negedge I_clock);
    end
    check_value("bresp", 32'(bresp), 32'd0);
  endtask

  task take_bresp();
    bready = 1'b1;
    wait_bvalid();
    @(posedge I_clock);
    @(negedge I_clock);
  endtask

  task axi_write(input reg_index_t idx, input logic[7:0] d, input logic[3:0] strb);
    write_addr_data(idx, d, strb);
    take_bresp();
    if (strb[0])
      model_write(idx, d);
  endtask

  task axi_read(input reg_index_t idx, output logic[7:0] d);
    int n;
    int cycles;
    araddr  = {idx, 2'b00};
    arvalid = 1'b1;
    n = 0;
    #1;
    while (!arready)
    begin
      if (n == WAIT_LIMIT)
        fail_timeout("read address handshake");
      n++;
      @(negedge I_clock);
      #1;
    end
    @(posedge I_clock);
    @(negedge I_clock);
    arvalid = 1'b0;
    cycles = 0;
    while (!rvalid)
    begin
      if (cycles == WAIT_LIMIT)
        fail_timeout("read data");
      @(posedge I_clock);
      cycles++;
      @(negedge I_clock);
    end
    check_value("read latency", 32'(cycles), 32'd3);
    check_value("rresp", 32'(rresp), 32'd0);
    check_value("rdata[31:8]", 32'(rdata[31:8]), 32'd0);
    d = rdata[7:0];
    @(posedge I_clock);                        // Taken with rready high.
    @(negedge I_clock);
  endtask

  task read_and_check(input reg_index_t idx, input string name);
    logic[7:0] got;
    logic[7:0] exp;
    bit        known;
    axi_read(idx, got);
    model_read(idx, exp, known);
    if (known)
      check_value(name, 32'(got), 32'(exp));
  endtask

  // ##########################################################
  // Directed tests
  // ##########################################################

  task test_reset_state();
    check_outputs();
    check_value("awready", 32'(awready), 32'd0);
    check_value("wready", 32'(wready), 32'd0);
    check_value("arready", 32'(arready), 32'd0);
    check_value("bvalid", 32'(bvalid), 32'd0);
    check_value("rvalid", 32'(rvalid), 32'd0);
  endtask

  task test_address_writes();
    axi_write(R_ppu_addr, 8'he1, 4'hf);        // Bits 7..6 fall away.
    axi_write(R_ppu_addr, rand_byte(), 4'hf);
    check_outputs();
    axi_write(R_ppu_addr, 8'h15, 4'hf);        // Leaves the latch set.
    I_vblank = 1'b1;
    read_and_check(R_ppu_stat, "status");
    I_vblank = 1'b0;
    read_and_check(R_ppu_stat, "status");
    axi_write(R_ppu_addr, 8'h3a, 4'hf);        // High byte again.
    axi_write(R_ppu_addr, 8'h80, 4'hf);
    check_outputs();
  endtask

  task test_scroll_control();
    repeat (3)
    begin
      axi_write(R_ppu_ctrl, rand_byte() & 8'h7b, 4'hf);
      axi_write(R_ppu_scrl, rand_byte(), 4'hf);
      check_outputs();
      axi_write(R_ppu_scrl, rand_byte(), 4'hf);
      check_outputs();
    end
    read_and_check(R_ppu_ctrl, "control");
    axi_write(R_ppu_addr, rand_byte(), 4'hf);
    axi_write(R_ppu_addr, rand_byte(), 4'hf);
    check_outputs();
  endtask

  task test_data_writes();
    axi_write(R_ppu_ctrl, 8'h00, 4'hf);
    axi_write(R_ppu_addr, 8'h21, 4'hf);
    axi_write(R_ppu_addr, 8'h00, 4'hf);
    repeat (4)
    begin
      axi_write(R_ppu_data, rand_byte(), 4'hf);
      check_outputs();
    end
    axi_write(R_ppu_ctrl, 8'h04, 4'hf);        // Step of 32.
    repeat (4)
    begin
      axi_write(R_ppu_data, rand_byte(), 4'hf);
      check_outputs();
    end
  endtask

  task test_buffered_reads();
    axi_write(R_ppu_ctrl, 8'h00, 4'hf);
    axi_write(R_ppu_addr, 8'h21, 4'hf);
    axi_write(R_ppu_addr, 8'h24, 4'hf);
    read_and_check(R_ppu_data, "data prime");  // Buffer content is unknown here.
    axi_write(R_ppu_addr, 8'h21, 4'hf);
    axi_write(R_ppu_addr, 8'h00, 4'hf);
    repeat (4)
    begin
      read_and_check(R_ppu_data, "data");
      check_outputs();
    end
  endtask

  task test_bus_behaviour();
    logic[7:0] first_mask;
    logic[7:0] second_mask;
    first_mask  = rand_byte();
    second_mask = rand_byte();
    bready = 1'b0;
    write_addr_data(R_ppu_mask, first_mask, 4'hf);
    wait_bvalid();
    model_write(R_ppu_mask, first_mask);
    awaddr  = {R_ppu_mask, 2'b00};
    wdata   = {24'd0, second_mask};
    awvalid = 1'b1;
    wvalid  = 1'b1;
    repeat (4)
    begin
      #1;
      check_value("awready", 32'(awready), 32'd0);
      check_value("bvalid", 32'(bvalid), 32'd1);
      @(negedge I_clock);
    end
    bready = 1'b1;
    write_addr_data(R_ppu_mask, second_mask, 4'hf);
    take_bresp();
    model_write(R_ppu_mask, second_mask);
    read_and_check(R_ppu_mask, "mask");
    axi_write(R_ppu_ctrl, 8'h03, 4'he);        // Lane 0 is off so nothing changes.
    axi_write(R_ppu_addr, 8'h3f, 4'h0);
    read_and_check(R_ppu_ctrl, "control");
    check_outputs();
  endtask

  initial
  begin
    I_reset = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b1;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b1;
    I_vblank = 1'b0;
    m_v = '0;
    m_t = '0;
    m_fx = '0;
    m_w = 1'b0;
    m_ctrl = '0;
    m_mask = '0;
    m_buf = '0;
    m_buf_known = 1'b0;
    repeat (8) @(posedge I_clock);
    @(negedge I_clock);
    test_reset_state();                        // Checked while still in reset.
    I_reset = 1'b1;
    @(negedge I_clock);
    test_reset_state();
    test_address_writes();
    test_scroll_control();
    test_data_writes();
    test_buffered_reads();
    test_bus_behaviour();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== hdl/video_regs_top.sv ====
`timescale 1ns/100ps
`include "ppu_consts.svh"

module video_regs_top
  import video_regdec_signals::*;
  import video_control_signals::*;
  (input  wire                        I_clock,
   input  wire                        I_reset,
   input  wire[`AXI_ADDR_W-1:0]       awaddr,
   input  wire                        awvalid,
   output wire                        awready,
   input  wire[`AXI_DATA_W-1:0]       wdata,
   input  wire[`AXI_DATA_W/8-1:0]     wstrb,
   input  wire                        wvalid,
   output wire                        wready,
   output wire[1:0]                   bresp,
   output wire                        bvalid,
   input  wire                        bready,
   input  wire[`AXI_ADDR_W-1:0]       araddr,
   input  wire                        arvalid,
   output wire                        arready,
   output wire[`AXI_DATA_W-1:0]       rdata,
   output wire[1:0]                   rresp,
   output wire                        rvalid,
   input  wire                        rready,
   input  wire                        I_vblank,
   output wire[`VID_ADDR_W-1:0]       O_vid_addr,
   output wire[2:0]                   O_vid_fine,
   output wire[14:0]                  O_scroll_addr);

  wire                               wr_strobe;
  wire                               rd_strobe;
  reg_index_t                        reg_sel;
  wire[`PPU_DATA_W-1:0]              wr_data;
  wire[`PPU_DATA_W-1:0]              rd_byte;
  wire[`PPU_REG_COUNT-1:0]           reg_wren;
  wire[`PPU_REG_COUNT-1:0]           reg_rden;
  wire[`PPU_DATA_W-1:0]              reg_data;
  ppu_control_t                      ctrl_word;
  wire[`PPU_DATA_W-1:0]              read_buffer;
  wire                               vid_wren;
  wire[`PPU_DATA_W-1:0]              vid_data;

  cpu_bus_axil cpu_bus_axil_i (
    .I_clock (I_clock), .I_reset (I_reset),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
    .wr_strobe (wr_strobe), .rd_strobe (rd_strobe), .reg_sel (reg_sel),
    .wr_data (wr_data), .rd_byte (rd_byte));

  video_regdec video_regdec_i (
    .I_clock (I_clock), .I_reset (I_reset),
    .wr_strobe (wr_strobe), .rd_strobe (rd_strobe), .reg_sel (reg_sel),
    .wr_data (wr_data), .I_vblank (I_vblank), .read_buffer (read_buffer),
    .reg_wren (reg_wren), .reg_rden (reg_rden), .reg_data (reg_data),
    .ctrl_word (ctrl_word), .rd_byte (rd_byte));

  video_address video_address_i (
    .I_clock (I_clock), .I_reset (I_reset),
    .I_wren (reg_wren), .I_rden (reg_rden), .I_data (reg_data), .I_control (ctrl_word),
    .O_vid_fine (O_vid_fine), .O_vid_addr (O_vid_addr), .O_vid_wren (vid_wren),
    .O_vid_data (vid_data), .O_scroll_addr (O_scroll_addr));

  vram_port vram_port_i (
    .I_clock (I_clock),
    .vid_addr (O_vid_addr), .vid_wren (vid_wren), .vid_data (vid_data),
    .data_rd (reg_rden[R_ppu_data]),        // Buffer reloads on every data read.
    .read_buffer (read_buffer));

endmodule

// ==== hdl/vram_port.sv ====
`timescale 1ns/100ps
`include "ppu_consts.svh"

module vram_port
  (I_clock,
   vid_addr,
   vid_wren,
   vid_data,
   data_rd,
   read_buffer);

  input  wire                        I_clock     ;

  input  wire[`VID_ADDR_W-1:0]       vid_addr    ;
  input  wire                        vid_wren    ;
  input  wire[`PPU_DATA_W-1:0]       vid_data    ;
  input  wire                        data_rd     ;
  output logic[`PPU_DATA_W-1:0]      read_buffer ;

  logic[`PPU_DATA_W-1:0]             mem [`VRAM_DEPTH];

  // ##########################################################
  // One write port and one buffered read port on a shared
  // address. The address advances on the same edge, so the
  // next access already sees the new location.
  // ##########################################################

  always_ff @(posedge I_clock)
  begin
    if (vid_wren)
      mem[vid_addr] <= vid_data;
  end

  always_ff @(posedge I_clock)
  begin
    if (data_rd)
      read_buffer <= mem[vid_addr];            // The host sees this on its next data read.
  end

endmodule

// ==== hdl/video_address.sv ====
`timescale 1ns/100ps
`include "ppu_consts.svh"

module video_address
  import video_regdec_signals::*;
  import video_control_signals::*;
  (I_clock,
   I_reset,
   I_wren,
   I_rden,
   I_data,
   I_control,
   O_vid_fine,
   O_vid_addr,
   O_vid_wren,
   O_vid_data,
   O_scroll_addr);

  input  wire                        I_clock       ;
  input  wire                        I_reset       ;

  input  wire[`PPU_REG_COUNT-1:0]    I_wren        ;
  input  wire[`PPU_REG_COUNT-1:0]    I_rden        ;
  input  wire[`PPU_DATA_W-1:0]       I_data        ;
  input  ppu_control_t               I_control     ;

  output wire[2:0]                   O_vid_fine    ;
  output wire[`VID_ADDR_W-1:0]       O_vid_addr    ;
  output wire                        O_vid_wren    ;
  output wire[`PPU_DATA_W-1:0]       O_vid_data    ;
  output wire[14:0]                  O_scroll_addr ;

  logic[14:0]                        v_addr;       // Current video address.
  logic[14:0]                        t_addr;       // Temporary scroll address.
  logic[2:0]                         v_fine;       // Fine horizontal scroll.
  logic                              w_latch;      // Second write of a pair is next.
  logic                              data_access;
  logic[14:0]                        v_step;

  assign data_access   = I_wren[R_ppu_data] | I_rden[R_ppu_data];
  assign v_step        = I_control.ctrl[C_vram_inc32] ? 15'd32 : 15'd1;

  assign O_vid_addr    = v_addr[`VID_ADDR_W-1:0];
  assign O_vid_fine    = v_fine;
  assign O_scroll_addr = t_addr;
  assign O_vid_wren    = I_wren[R_ppu_data];   // Memory write at the current address.
  assign O_vid_data    = I_data;

  always_ff @(posedge I_clock, negedge I_reset)
  begin
    if (~I_reset)
    begin
      v_addr  <= 15'd0;
      t_addr  <= 15'd0;
      v_fine  <= 3'd0;
      w_latch <= 1'b0;
    end else
    begin
      if (I_rden[R_ppu_stat])
        w_latch <= 1'b0;                       // Status read restarts the pair.
      else if (I_wren[R_ppu_scrl] | I_wren[R_ppu_addr])
        w_latch <= ~w_latch;

      if (I_wren[R_ppu_ctrl])
        t_addr[11:10] <= I_data[C_nt_select_hi:C_nt_select_lo];
      else if (I_wren[R_ppu_scrl] & ~w_latch)
      begin
        t_addr[4:0] <= I_data[7:3];            // Coarse X.
        v_fine      <= I_data[2:0];
      end else if (I_wren[R_ppu_scrl])
      begin
        t_addr[9:5]   <= I_data[7:3];          // Coarse Y.
        t_addr[14:12] <= I_data[2:0];          // Fine Y.
      end else if (I_wren[R_ppu_addr] & ~w_latch)
      begin
        t_addr[14]   <= 1'b0;
        t_addr[13:8] <= I_data[5:0];
      end else if (I_wren[R_ppu_addr])
        t_addr[7:0] <= I_data;

      if (I_wren[R_ppu_addr] & w_latch)
        v_addr <= {t_addr[14:8], I_data};      // Second address write copies the pair.
      else if (data_access)
        v_addr <= v_addr + v_step;
    end
  end

  a_one_wren : assert property (@(posedge I_clock) disable iff (~I_reset)
                                $onehot0(I_wren));

endmodule

// ==== hdl/video_regdec.sv ====
`timescale 1ns/100ps
`include "ppu_consts.svh"

module video_regdec
  import video_regdec_signals::*;
  import video_control_signals::*;
  (I_clock,
   I_reset,
   wr_strobe,
   rd_strobe,
   reg_sel,
   wr_data,
   I_vblank,
   read_buffer,
   reg_wren,
   reg_rden,
   reg_data,
   ctrl_word,
   rd_byte);

  input  wire                        I_clock     ;
  input  wire                        I_reset     ;

  input  wire                        wr_strobe   ;
  input  wire                        rd_strobe   ;
  input  reg_index_t                 reg_sel     ;
  input  wire[`PPU_DATA_W-1:0]       wr_data     ;
  input  wire                        I_vblank    ;
  input  wire[`PPU_DATA_W-1:0]       read_buffer ;

  output logic[`PPU_REG_COUNT-1:0]   reg_wren    ;
  output logic[`PPU_REG_COUNT-1:0]   reg_rden    ;
  output logic[`PPU_DATA_W-1:0]      reg_data    ;
  output ppu_control_t               ctrl_word   ;
  output logic[`PPU_DATA_W-1:0]      rd_byte     ;

  logic[`PPU_REG_COUNT-1:0]          sel_onehot;
  logic[`PPU_DATA_W-1:0]             src_byte;

  assign sel_onehot = {{(`PPU_REG_COUNT-1){1'b0}}, 1'b1} << reg_sel;

  // The read source is sampled on the same edge where the read strobe acts downstream.
  always_comb
  begin
    src_byte = '0;
    if (reg_rden[R_ppu_stat])
      src_byte[S_vblank] = I_vblank;
    else if (reg_rden[R_ppu_ctrl])
      src_byte = ctrl_word.ctrl;
    else if (reg_rden[R_ppu_mask])
      src_byte = ctrl_word.mask;
    else if (reg_rden[R_ppu_data])
      src_byte = read_buffer;                  // Old buffer content while the buffer reloads.
  end

  always_ff @(posedge I_clock, negedge I_reset)
  begin
    if (~I_reset)
    begin
      reg_wren  <= '0;
      reg_rden  <= '0;
      ctrl_word <= '0;
    end else
    begin
      reg_wren <= wr_strobe ? sel_onehot : '0;
      reg_rden <= rd_strobe ? sel_onehot : '0;

      if (reg_wren[R_ppu_ctrl])
        ctrl_word.ctrl <= reg_data;
      if (reg_wren[R_ppu_mask])
        ctrl_word.mask <= reg_data;
    end
  end

  always_ff @(posedge I_clock)
  begin
    if (wr_strobe)
      reg_data <= wr_data;
    if (|reg_rden)
      rd_byte <= src_byte;
  end

  a_no_rd_wr : assert property (@(posedge I_clock) disable iff (~I_reset)
                                !((|reg_wren) && (|reg_rden)));

endmodule

// ==== hdl/cpu_bus_axil.sv ====
`timescale 1ns/100ps
`include "ppu_consts.svh"

module cpu_bus_axil
  import video_regdec_signals::*;
  (I_clock,
   I_reset,
   awaddr,
   awvalid,
   awready,
   wdata,
   wstrb,
   wvalid,
   wready,
   bresp,
   bvalid,
   bready,
   araddr,
   arvalid,
   arready,
   rdata,
   rresp,
   rvalid,
   rready,
   wr_strobe,
   rd_strobe,
   reg_sel,
   wr_data,
   rd_byte);

  input  wire                        I_clock   ;
  input  wire                        I_reset   ;

  input  wire[`AXI_ADDR_W-1:0]       awaddr    ;
  input  wire                        awvalid   ;
  output wire                        awready   ;
  input  wire[`AXI_DATA_W-1:0]       wdata     ;
  input  wire[`AXI_DATA_W/8-1:0]     wstrb     ;
  input  wire                        wvalid    ;
  output wire                        wready    ;
  output wire[1:0]                   bresp     ;
  output logic                       bvalid    ;
  input  wire                        bready    ;

  input  wire[`AXI_ADDR_W-1:0]       araddr    ;
  input  wire                        arvalid   ;
  output wire                        arready   ;
  output logic[`AXI_DATA_W-1:0]      rdata     ;
  output wire[1:0]                   rresp     ;
  output logic                       rvalid    ;
  input  wire                        rready    ;

  output logic                       wr_strobe ;
  output logic                       rd_strobe ;
  output reg_index_t                 reg_sel   ;
  output logic[`PPU_DATA_W-1:0]      wr_data   ;
  input  wire[`PPU_DATA_W-1:0]       rd_byte   ;

  logic                              aw_take;  // Write address and data taken this cycle.
  logic                              ar_take;  // Read address taken this cycle.
  logic                              w_issue;  // Write went into the pipeline last cycle.
  logic[1:0]                         r_wait;   // Cycles left until the read byte is ready.

  assign ar_take = arvalid & ~rvalid & (r_wait == 2'd0);
  assign aw_take = awvalid & wvalid & ~w_issue & ~bvalid & ~ar_take;  // Reads win a tie.

  assign arready = ar_take;
  assign awready = aw_take;
  assign wready  = aw_take;
  assign bresp   = 2'b00;                      // Always OKAY.
  assign rresp   = 2'b00;

  always_ff @(posedge I_clock, negedge I_reset)
  begin
    if (~I_reset)
    begin
      wr_strobe <= 1'b0;
      rd_strobe <= 1'b0;
      w_issue   <= 1'b0;
      bvalid    <= 1'b0;
      r_wait    <= 2'd0;
      rvalid    <= 1'b0;
    end else
    begin
      wr_strobe <= aw_take & wstrb[0];         // Byte lane 0 carries the register.
      rd_strobe <= ar_take;
      w_issue   <= aw_take;

      if (w_issue)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;

      if (ar_take)
        r_wait <= 2'd3;
      else if (r_wait != 2'd0)
        r_wait <= r_wait - 2'd1;

      if (r_wait == 2'd1)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  always_ff @(posedge I_clock)
  begin
    if (aw_take)
    begin
      reg_sel <= reg_index_t'(awaddr[4:2]);
      wr_data <= wdata[`PPU_DATA_W-1:0];
    end else if (ar_take)
      reg_sel <= reg_index_t'(araddr[4:2]);

    if (r_wait == 2'd1)
      rdata <= {{(`AXI_DATA_W-`PPU_DATA_W){1'b0}}, rd_byte};  // Byte from the decoder stage.
  end

  a_bvalid_hold : assert property (@(posedge I_clock) disable iff (~I_reset)
                                   bvalid & ~bready |=> bvalid);
  a_rvalid_hold : assert property (@(posedge I_clock) disable iff (~I_reset)
                                   rvalid & ~rready |=> rvalid & $stable(rdata));

endmodule

// ==== hdl/video_control_signals.sv ====
package video_control_signals;

  typedef struct packed
  {
    logic [7:0] mask;                          // Mask byte written through register 1.
    logic [7:0] ctrl;                          // Control byte written through register 0.
  } ppu_control_t;

  // Bit positions inside the control byte.
  localparam int C_nt_select_lo = 0;           // Low bit of the nametable select.
  localparam int C_nt_select_hi = 1;           // High bit of the nametable select.
  localparam int C_vram_inc32   = 2;           // Step of 32 instead of 1 after a data access.
  localparam int C_nmi_enable   = 7;           // Kept for a future interrupt source.

  // Bit positions inside the status byte.
  localparam int S_vblank       = 7;           // Vertical blank flag.

endpackage

// ==== hdl/video_regdec_signals.sv ====
package video_regdec_signals;

  // The index follows address bits 4..2 of the host bus.
  typedef enum logic [2:0]
  {
    R_ppu_ctrl = 3'd0,
    R_ppu_mask = 3'd1,
    R_ppu_stat = 3'd2,
    R_oam_addr = 3'd3,
    R_oam_data = 3'd4,
    R_ppu_scrl = 3'd5,
    R_ppu_addr = 3'd6,
    R_ppu_data = 3'd7
  } reg_index_t;

endpackage

// ==== hdl/ppu_consts.svh ====
`ifndef PPU_CONSTS_SVH
`define PPU_CONSTS_SVH

// Register file.
`define PPU_REG_COUNT 8
`define PPU_DATA_W    8

// Video memory.
`define VID_ADDR_W    14
`define VRAM_DEPTH    16384

// Host bus with the register index in address bits 4..2.
`define AXI_ADDR_W    5
`define AXI_DATA_W    32

`endif
